//--- tg_pkg.sv
`default_nettype none

package tg_pkg;

    // memory geometry
    localparam int LINE_W  = 128;
    localparam int ADDR_W  = 24;
    localparam int COLOR_W = 16;

    // display frame, one 128-bit line per request
    localparam int HDMI_LINES = 115200;

    // accumulator region starts at line address bit 21
    localparam logic [ADDR_W-1:0] RTX_BASE = 24'h20_0000;

    // in-flight tags; writeback queue shares the depth
    localparam int TAG_DEPTH = 64;

    typedef enum logic [1:0] {
        READ_HDMI,
        FETCH_ADD,
        FETCH_OVERWRITE,
        WRITE_BACK
    } req_kind_t;

    // one accepted request, kept until its completion
    typedef struct packed {
        req_kind_t            kind;
        logic [ADDR_W-1:0]    addr;
        logic [COLOR_W-1:0]   color;
    } tag_t;

    // one merged line waiting for a write slot
    typedef struct packed {
        logic [ADDR_W-1:0]    addr;
        logic [LINE_W-1:0]    data;
    } wb_t;

    // accumulator pixel, half a line, red in the low bits
    typedef struct packed {
        logic [20:0]          blue;
        logic [21:0]          green;
        logic [20:0]          red;
    } accum_px_t;

    // two pixels share a line
    function automatic logic [ADDR_W-1:0] accum_line(input logic [ADDR_W-1:0] pix_addr);
        return (pix_addr >> 1) | RTX_BASE;
    endfunction

endpackage

`default_nettype wire

//--- cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  item_t din,
    input  logic  pop,
    output item_t dout,
    output logic  full,
    output logic  empty
);

    // entry storage
    item_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic do_push;
    logic do_pop;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);

    // drop push on full, pop on empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head of queue
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- request_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module request_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    // pixel request, kind already set from tlast
    input  tg_pkg::tag_t              pix,
    input  logic                      pix_valid,
    output logic                      pix_ready,
    // display stream almost full
    input  logic                      read_af,
    input  logic                      busy,
    // writeback queue head
    input  tg_pkg::wb_t               wb_head,
    input  logic                      wb_empty,
    output logic                      wb_pop,
    // in-flight tag queue
    input  logic                      tag_full,
    output logic                      tag_push,
    output tg_pkg::tag_t              tag_out,
    // memory command
    output logic [tg_pkg::ADDR_W-1:0] mem_addr,
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [tg_pkg::LINE_W-1:0] mem_wdata
);
    import tg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD,
        ST_WR
    } slot_t;

    slot_t state;
    logic [ADDR_W-1:0] line_cnt;
    logic can_issue;
    logic rd_go;
    logic wb_go;
    logic fetch_go;

    // one idle cycle out of reset, then read/write every other cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: state <= ST_RD;
                ST_RD:   state <= ST_WR;
                ST_WR:   state <= ST_RD;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // memory free and room for another tag
    assign can_issue = !busy && !tag_full;

    // display read, held off by almost full
    assign rd_go = (state == ST_RD) && !read_af && can_issue;

    // pending writeback wins the write slot
    assign wb_go     = (state == ST_WR) && !wb_empty && can_issue;
    assign pix_ready = (state == ST_WR) && wb_empty && can_issue;
    assign fetch_go  = pix_ready && pix_valid;

    assign mem_en   = rd_go || wb_go || fetch_go;
    assign mem_we   = wb_go;
    assign wb_pop   = wb_go;
    // every accepted request leaves a tag
    assign tag_push = mem_en;

    // display line walker, wraps at end of frame
    always_ff @(posedge clk) begin
        if (rst) begin
            line_cnt <= '0;
        end else if (rd_go) begin
            if (line_cnt == ADDR_W'(HDMI_LINES - 1)) begin
                line_cnt <= '0;
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    // address, data and tag for whichever request goes out
    always_comb begin
        mem_addr  = '0;
        mem_wdata = '0;
        tag_out   = '{kind: READ_HDMI, addr: line_cnt, color: '0};
        if (wb_go) begin
            mem_addr  = wb_head.addr;
            mem_wdata = wb_head.data;
            tag_out   = '{kind: WRITE_BACK, addr: wb_head.addr, color: '0};
        end else if (fetch_go) begin
            // fetch the line holding the pixel pair
            mem_addr = accum_line(pix.addr);
            tag_out  = pix;
        end else if (rd_go) begin
            mem_addr = line_cnt;
        end
    end

endmodule

`default_nettype wire

//--- response_merge.sv
`timescale 1ns/1ps
`default_nettype none

module response_merge (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      complete,
    input  logic [tg_pkg::LINE_W-1:0] resp_data,
    // head of the in-flight tag queue
    input  tg_pkg::tag_t              tag,
    output logic                      tag_pop,
    output logic                      wb_push,
    output tg_pkg::wb_t               wb_out,
    output logic [tg_pkg::LINE_W-1:0] rd_data,
    output logic                      rd_valid,
    output logic                      rd_last
);
    import tg_pkg::*;

    logic is_disp;
    logic is_fetch;
    logic overwrite;
    accum_px_t old_px;
    accum_px_t in_px;
    accum_px_t new_px;
    logic [LINE_W-1:0] merged;

    // completions come back in issue order
    assign tag_pop = complete;

    assign is_disp   = (tag.kind == READ_HDMI);
    assign overwrite = (tag.kind == FETCH_OVERWRITE);
    assign is_fetch  = (tag.kind == FETCH_ADD) || overwrite;

    always_comb begin
        // odd pixel in the low half
        old_px = tag.addr[0] ? resp_data[63:0] : resp_data[127:64];

        // rgb565 unpack, fields zero-extend
        in_px.red   = tag.color[4:0];
        in_px.green = tag.color[10:5];
        in_px.blue  = tag.color[15:11];

        // add wraps at channel width
        new_px.red   = overwrite ? in_px.red : old_px.red + in_px.red;
        new_px.green = overwrite ? in_px.green : old_px.green + in_px.green;
        new_px.blue  = overwrite ? in_px.blue : old_px.blue + in_px.blue;

        // other half passes through
        if (tag.addr[0]) begin
            merged = {resp_data[127:64], new_px};
        end else begin
            merged = {new_px, resp_data[63:0]};
        end
    end

    // strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            wb_push  <= 1'b0;
        end else begin
            rd_valid <= complete && is_disp;
            // write_back completions only pop
            wb_push  <= complete && is_fetch;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (complete && is_disp) begin
            rd_data <= resp_data;
            rd_last <= (tag.addr == ADDR_W'(HDMI_LINES - 1));
        end
        if (complete && is_fetch) begin
            wb_out.addr <= accum_line(tag.addr);
            wb_out.data <= merged;
        end
    end

endmodule

`default_nettype wire

//--- traffic_generator.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_generator (
    input  logic                       clk,
    input  logic                       rst,
    // ddr3 controller
    output logic [tg_pkg::ADDR_W-1:0]  memrequest_addr,
    output logic                       memrequest_en,
    output logic [tg_pkg::LINE_W-1:0]  memrequest_write_data,
    output logic                       memrequest_write_enable,
    input  logic [tg_pkg::LINE_W-1:0]  memrequest_resp_data,
    input  logic                       memrequest_complete,
    input  logic                       memrequest_busy,
    // pixel stream in
    input  logic [tg_pkg::COLOR_W-1:0] write_axis_data,
    input  logic [tg_pkg::ADDR_W-1:0]  write_axis_addr,
    input  logic                       write_axis_tlast,
    input  logic                       write_axis_valid,
    output logic                       write_axis_ready,
    // display stream out
    output logic [tg_pkg::LINE_W-1:0]  read_axis_data,
    output logic                       read_axis_tlast,
    output logic                       read_axis_valid,
    input  logic                       read_axis_af
);
    import tg_pkg::*;

    tag_t pix;
    tag_t tag_in;
    tag_t tag_head;
    logic tag_push;
    logic tag_pop;
    logic tag_full;
    wb_t  wb_in;
    wb_t  wb_head;
    logic wb_push;
    logic wb_pop;
    logic wb_empty;

    // tlast marks an overwrite
    assign pix = '{kind:  write_axis_tlast ? FETCH_OVERWRITE : FETCH_ADD,
                   addr:  write_axis_addr,
                   color: write_axis_data};

    request_arbiter arbiter (
        .clk(clk), .rst(rst),
        .pix(pix), .pix_valid(write_axis_valid), .pix_ready(write_axis_ready),
        .read_af(read_axis_af), .busy(memrequest_busy),
        .wb_head(wb_head), .wb_empty(wb_empty), .wb_pop(wb_pop),
        .tag_full(tag_full), .tag_push(tag_push), .tag_out(tag_in),
        .mem_addr(memrequest_addr), .mem_en(memrequest_en),
        .mem_we(memrequest_write_enable), .mem_wdata(memrequest_write_data)
    );

    // in-flight tags; empty unused since every complete has a tag
    cmd_fifo #(.item_t(tag_t), .DEPTH(TAG_DEPTH)) tag_fifo (
        .clk(clk), .rst(rst),
        .push(tag_push), .din(tag_in), .pop(tag_pop), .dout(tag_head),
        .full(tag_full), .empty()
    );

    // merged lines; depth matches tag fifo so full never rises
    cmd_fifo #(.item_t(wb_t), .DEPTH(TAG_DEPTH)) wb_fifo (
        .clk(clk), .rst(rst),
        .push(wb_push), .din(wb_in), .pop(wb_pop), .dout(wb_head),
        .full(), .empty(wb_empty)
    );

    response_merge merge (
        .clk(clk), .rst(rst),
        .complete(memrequest_complete), .resp_data(memrequest_resp_data),
        .tag(tag_head), .tag_pop(tag_pop),
        .wb_push(wb_push), .wb_out(wb_in),
        .rd_data(read_axis_data), .rd_valid(read_axis_valid), .rd_last(read_axis_tlast)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [tg_pkg::ADDR_W-1:0] addr,
    input  logic                      en,
    input  logic                      we,
    input  logic [tg_pkg::LINE_W-1:0] wdata,
    output logic                      busy,
    output logic                      complete,
    output logic [tg_pkg::LINE_W-1:0] resp_data
);
    import tg_pkg::*;

    // sparse line store, unwritten lines read back as the fill pattern
    logic [LINE_W-1:0] store [logic [ADDR_W-1:0]];
    // pending requests in issue order, with their completion cycle
    logic [ADDR_W-1:0] pend_addr [$];
    longint pend_due [$];
    longint now;
    longint last_due;
    longint due;
    logic [ADDR_W-1:0] done_addr;
    integer seed = 92;

    // preload pattern, every address bit takes part
    function automatic logic [LINE_W-1:0] fill_line(input logic [ADDR_W-1:0] a);
        logic [31:0] h;
        h = {8'h5a, a} * 32'h9e37_79b1;
        return {h, ~h, h ^ 32'h0f0f_0f0f, 8'hc3, a};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            complete  <= 1'b0;
            resp_data <= '0;
            pend_addr.delete();
            pend_due.delete();
            now      = 0;
            last_due = 0;
        end else begin
            now = now + 1;
            complete <= 1'b0;
            // oldest request completes once its latency ran out
            if (pend_due.size() > 0 && pend_due[0] <= now) begin
                done_addr = pend_addr.pop_front();
                void'(pend_due.pop_front());
                complete  <= 1'b1;
                resp_data <= store.exists(done_addr) ? store[done_addr] : fill_line(done_addr);
            end
            if (en) begin
                // write data lands at once
                if (we) begin
                    store[addr] = wdata;
                end
                // 1 to 4 cycles
                due = now + 1 + longint'($random(seed) & 3);
                // one completion per cycle, never ahead of an older one
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_addr.push_back(addr);
                pend_due.push_back(due);
            end
            // random stall, about one cycle in four
            busy <= (($random(seed) & 7) < 2);
        end
    end

endmodule

`default_nettype wire

//--- tb_traffic_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_traffic_generator;
    import tg_pkg::*;

    localparam int NUM_PIX         = 200;
    localparam int WATCHDOG_CYCLES = HDMI_LINES * 12;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [ADDR_W-1:0] mem_addr;
    logic mem_en;
    logic mem_we;
    logic [LINE_W-1:0] mem_wdata;
    logic [LINE_W-1:0] mem_rdata;
    logic mem_complete;
    logic mem_busy;
    logic [COLOR_W-1:0] write_axis_data = '0;
    logic [ADDR_W-1:0] write_axis_addr = '0;
    logic write_axis_tlast = 1'b0;
    logic write_axis_valid = 1'b0;
    logic write_axis_ready;
    logic [LINE_W-1:0] read_axis_data;
    logic read_axis_tlast;
    logic read_axis_valid;
    logic read_axis_af = 1'b0;

    integer seed = 92;
    logic rst_d = 1'b0;
    int disp_idx = 0;
    logic frame_done = 1'b0;
    // expected writebacks, oldest first
    logic [ADDR_W-1:0] exp_addr [$];
    logic [LINE_W-1:0] exp_data [$];

    traffic_generator uut (
        .clk(clk), .rst(rst),
        .memrequest_addr(mem_addr), .memrequest_en(mem_en),
        .memrequest_write_data(mem_wdata), .memrequest_write_enable(mem_we),
        .memrequest_resp_data(mem_rdata), .memrequest_complete(mem_complete),
        .memrequest_busy(mem_busy),
        .write_axis_data(write_axis_data), .write_axis_addr(write_axis_addr),
        .write_axis_tlast(write_axis_tlast), .write_axis_valid(write_axis_valid),
        .write_axis_ready(write_axis_ready),
        .read_axis_data(read_axis_data), .read_axis_tlast(read_axis_tlast),
        .read_axis_valid(read_axis_valid), .read_axis_af(read_axis_af)
    );

    tb_mem_model mem (
        .clk(clk), .rst(rst), .addr(mem_addr), .en(mem_en), .we(mem_we),
        .wdata(mem_wdata), .busy(mem_busy), .complete(mem_complete), .resp_data(mem_rdata)
    );

    always #10 clk = ~clk;

    // same line pattern the memory starts with
    function automatic logic [LINE_W-1:0] expected_fill(input logic [ADDR_W-1:0] a);
        logic [31:0] h;
        h = {8'h5a, a} * 32'h9e37_79b1;
        return {h, ~h, h ^ 32'h0f0f_0f0f, 8'hc3, a};
    endfunction

    // accumulator line after one pixel, odd pixel in the low half
    function automatic logic [LINE_W-1:0] merged_line(input logic [ADDR_W-1:0] pa,
                                                      input logic [COLOR_W-1:0] c,
                                                      input logic ovr);
        logic [LINE_W-1:0] old;
        logic [63:0] half;
        logic [20:0] r;
        logic [21:0] g;
        logic [20:0] b;
        old  = expected_fill((pa >> 1) | RTX_BASE);
        half = pa[0] ? old[63:0] : old[127:64];
        r = ovr ? 21'(c[4:0]) : half[20:0] + 21'(c[4:0]);
        g = ovr ? 22'(c[10:5]) : half[42:21] + 22'(c[10:5]);
        b = ovr ? 21'(c[15:11]) : half[63:43] + 21'(c[15:11]);
        half = {b, g, r};
        return pa[0] ? {old[127:64], half} : {half, old[63:0]};
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // hold one pixel until the DUT takes it
    task automatic send_pixel(input logic [ADDR_W-1:0] pa, input logic [COLOR_W-1:0] c,
                              input logic last);
        write_axis_valid <= 1'b1;
        write_axis_addr  <= pa;
        write_axis_data  <= c;
        write_axis_tlast <= last;
        @(posedge clk);
        while (!write_axis_ready) @(posedge clk);
        write_axis_valid <= 1'b0;
    endtask

    // display almost full toggles at random
    always @(posedge clk) begin
        read_axis_af <= !rst && (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        rst_d <= rst;
        // quiet in reset and in the idle cycle after it
        if (rst_d) begin
            assert (!mem_en && !mem_we && !write_axis_ready && !read_axis_valid)
                else report_error("strobe high during or right after reset");
        end
        if (!rst) begin
            assert (!(mem_en && mem_busy)) else report_error("request while busy");
            assert (!(write_axis_ready && mem_busy)) else report_error("ready while busy");
            // no display read under back-pressure
            if (read_axis_af && mem_en) begin
                assert (mem_we || mem_addr >= RTX_BASE)
                    else report_error($sformatf("display read %h while af high", mem_addr));
            end
            // display lines in order, tlast only on the final one
            if (read_axis_valid) begin
                assert (read_axis_data == expected_fill(ADDR_W'(disp_idx % HDMI_LINES)))
                    else report_error($sformatf("line %0d data %h", disp_idx, read_axis_data));
                assert (read_axis_tlast == (disp_idx % HDMI_LINES == HDMI_LINES - 1))
                    else report_error($sformatf("line %0d tlast %b", disp_idx, read_axis_tlast));
                disp_idx = disp_idx + 1;
                if (disp_idx == HDMI_LINES) begin
                    frame_done <= 1'b1;
                end
            end
            // accepted pixel, predict its writeback
            if (write_axis_valid && write_axis_ready) begin
                exp_addr.push_back((write_axis_addr >> 1) | RTX_BASE);
                exp_data.push_back(merged_line(write_axis_addr, write_axis_data,
                                               write_axis_tlast));
            end
            if (mem_en && mem_we) begin
                assert (exp_addr.size() > 0) else report_error("writeback without a pixel");
                assert (mem_addr == exp_addr[0] && mem_wdata == exp_data[0])
                    else report_error($sformatf("writeback %h data %h, expected %h data %h",
                                               mem_addr, mem_wdata, exp_addr[0], exp_data[0]));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // every pixel on its own line, tlast about one in four
        for (int i = 0; i < NUM_PIX; i++) begin
            send_pixel(ADDR_W'(i * 4099 * 2) | ADDR_W'($random(seed) & 1),
                       COLOR_W'($random(seed)), ($random(seed) & 3) == 0);
            repeat ($random(seed) & 3) @(posedge clk);
        end
        while (!(frame_done && exp_addr.size() == 0)) @(posedge clk);
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the frame or the pixel writebacks never finished");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- traffic_generator.f
tg_pkg.sv
cmd_fifo.sv
request_arbiter.sv
response_merge.sv
traffic_generator.sv
tb_mem_model.sv
tb_traffic_generator.sv

//--- Makefile
SRCS := $(shell cat traffic_generator.f)

obj_dir/Vtb_traffic_generator: traffic_generator.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_traffic_generator -f traffic_generator.f

run: obj_dir/Vtb_traffic_generator
	./obj_dir/Vtb_traffic_generator

clean:
	rm -rf obj_dir

.PHONY: run clean
